//--- source/front_end_pkg.sv
package front_end_pkg;

	// one instruction word or one byte address
	typedef logic [31:0] rv32i_word;

	// widest global history that travels with an instruction
	localparam int max_history = 16;

	// first address fetched when rst_n is released
	localparam rv32i_word reset_pc = 32'h0000_0000;

	// sequential fetch stride, rv32i has no compressed forms here
	localparam rv32i_word pc_step = 32'd4;

	// two-bit counter encodings
	localparam logic [1:0] strong_not_taken = 2'b00;
	localparam logic [1:0] weak_not_taken   = 2'b01;
	localparam logic [1:0] weak_taken       = 2'b10;
	localparam logic [1:0] strong_taken     = 2'b11;

	// prediction that rides along with one fetched instruction
	typedef struct packed {
		logic                   taken;   // direction guess used by fetch
		rv32i_word              target;  // btb target at fetch time
		logic [max_history-1:0] bhr;     // speculative history before this fetch
	} predict_state;

	// saturating step of a two-bit counter
	function automatic logic [1:0] counter_step(input logic [1:0] count, input logic up);
		logic [1:0] result;
		result = count;
		if (up && count != strong_taken)
			result = count + 2'd1;  // climb toward strongly taken
		else if (!up && count != strong_not_taken)
			result = count - 2'd1;  // fall toward strongly not taken
		return result;
	endfunction

	// counter upper bit is the direction
	function automatic logic counter_taken(input logic [1:0] count);
		return count[1];
	endfunction

endpackage

//--- source/gshare_predictor.sv
module gshare_predictor #(
	parameter int history_bits = 5
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  front_end_pkg::rv32i_word              fetch_pc,
	input  logic                                  fetch_advance,
	input  logic                                  update_valid,
	input  front_end_pkg::rv32i_word              update_pc,
	input  logic                                  update_taken,
	input  logic [front_end_pkg::max_history-1:0] update_bhr,
	input  logic                                  mispredict,
	output logic                                  taken,
	output logic [front_end_pkg::max_history-1:0] bhr
);
	import front_end_pkg::*;

	localparam int table_size = 2 ** history_bits;

	logic [1:0]              pht [table_size];  // pattern history table
	logic [history_bits-1:0] ghr;               // speculative global history
	logic [history_bits-1:0] fetch_idx;
	logic [history_bits-1:0] update_idx;
	logic [history_bits:0]   shifted_hist;      // ghr with the new guess appended
	logic [history_bits:0]   repaired_hist;     // snapshot with the real outcome appended

	// word address bits hashed with history
	assign fetch_idx  = fetch_pc[history_bits+1:2] ^ ghr;
	assign update_idx = update_pc[history_bits+1:2] ^ update_bhr[history_bits-1:0];

	assign taken = counter_taken(pht[fetch_idx]);  // upper bit of the counter

	assign shifted_hist  = {ghr, taken};
	assign repaired_hist = {update_bhr[history_bits-1:0], update_taken};

	always_comb
	begin
		bhr                    = '0;   // unused upper bits stay zero
		bhr[history_bits-1:0]  = ghr;  // snapshot before this fetch shifts
	end

	// counters train on every resolved branch
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < table_size; i++)
				pht[i] <= weak_not_taken;
		end
		else if (update_valid)
		begin
			pht[update_idx] <= counter_step(pht[update_idx], update_taken);
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ghr <= '0;
		end
		else if (update_valid && mispredict)
		begin
			ghr <= repaired_hist[history_bits-1:0];  // rebuild from the resolved path
		end
		else if (fetch_advance)
		begin
			ghr <= shifted_hist[history_bits-1:0];  // oldest bit drops off
		end
	end

endmodule

//--- source/branch_target_buffer.sv
module branch_target_buffer #(
	parameter int btb_index_bits = 6
) (
	input  logic                     clk,
	input  logic                     rst_n,
	input  front_end_pkg::rv32i_word fetch_pc,
	input  logic                     update_valid,
	input  logic                     update_taken,
	input  front_end_pkg::rv32i_word update_pc,
	input  front_end_pkg::rv32i_word update_target,
	output front_end_pkg::rv32i_word target,
	output logic                     hit
);
	import front_end_pkg::*;

	localparam int entries  = 2 ** btb_index_bits;
	localparam int tag_bits = 30 - btb_index_bits;  // word address bits above the index

	rv32i_word             target_mem [entries];
	logic [tag_bits-1:0]   tag_mem [entries];
	logic [entries-1:0]    valid_q;

	logic [btb_index_bits-1:0] fetch_idx;
	logic [btb_index_bits-1:0] update_idx;
	logic [tag_bits-1:0]       fetch_tag;
	logic [tag_bits-1:0]       update_tag;
	logic                      fill;

	// byte offset bits are skipped
	assign fetch_idx  = fetch_pc[btb_index_bits+1:2];
	assign fetch_tag  = fetch_pc[31:btb_index_bits+2];
	assign update_idx = update_pc[btb_index_bits+1:2];
	assign update_tag = update_pc[31:btb_index_bits+2];

	assign fill = update_valid && update_taken;  // only taken branches allocate

	// lookup
	assign target = target_mem[fetch_idx];
	assign hit    = valid_q[fetch_idx] && (tag_mem[fetch_idx] == fetch_tag);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_q <= '0;  // table starts empty
		end
		else if (fill)
		begin
			valid_q[update_idx] <= 1'b1;
		end
	end

	// tag and target arrays follow valid_q
	always_ff @(posedge clk)
	begin
		if (fill)
		begin
			tag_mem[update_idx]    <= update_tag;
			target_mem[update_idx] <= update_target;  // newest target replaces the old one
		end
	end

endmodule

//--- source/fetch_stage.sv
module fetch_stage #(
	parameter int history_bits   = 5,
	parameter int btb_index_bits = 6
) (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  resp,
	input  front_end_pkg::rv32i_word              rdata,
	input  logic                                  redirect,
	input  front_end_pkg::rv32i_word              redirect_pc,
	input  logic                                  update_valid,
	input  front_end_pkg::rv32i_word              update_pc,
	input  logic                                  update_taken,
	input  front_end_pkg::rv32i_word              update_target,
	input  logic [front_end_pkg::max_history-1:0] update_bhr,
	input  logic                                  mispredict,
	output logic                                  read,
	output front_end_pkg::rv32i_word              address,
	output logic                                  fetch_valid,
	output front_end_pkg::rv32i_word              fetch_pc,
	output front_end_pkg::rv32i_word              fetch_instr,
	output front_end_pkg::predict_state           fetch_predict
);
	import front_end_pkg::*;

	rv32i_word              pc;           // address of the read in flight
	rv32i_word              next_pc;
	rv32i_word              btb_target;
	logic                   btb_hit;
	logic                   dir_taken;    // gshare direction
	logic                   predict_taken;
	logic [max_history-1:0] spec_bhr;
	logic                   accept;       // response is kept

	// a response during a redirect, or while read is low, belongs to the old path
	assign accept        = resp && read && !redirect;
	assign predict_taken = dir_taken && btb_hit;  // need both direction and a target

	// next pc priority
	always_comb
	begin
		if (redirect)
			next_pc = redirect_pc;  // resolve overrides everything
		else if (predict_taken)
			next_pc = btb_target;
		else
			next_pc = pc + pc_step;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc   <= reset_pc;
			read <= 1'b1;  // first read starts right out of reset
		end
		else
		begin
			read <= !redirect;  // one idle cycle cancels the stale request
			if (redirect || accept)
				pc <= next_pc;
		end
	end

	assign address = pc;

	// handed to the fetch/decode register on the resp edge
	assign fetch_valid          = accept;
	assign fetch_pc             = pc;
	assign fetch_instr          = rdata;
	assign fetch_predict.taken  = predict_taken;
	assign fetch_predict.target = btb_target;
	assign fetch_predict.bhr    = spec_bhr;

	gshare_predictor #(
		.history_bits (history_bits)
	) gshare0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.fetch_pc      (pc),
		.fetch_advance (accept),  // history shifts once per kept fetch
		.update_valid  (update_valid),
		.update_pc     (update_pc),
		.update_taken  (update_taken),
		.update_bhr    (update_bhr),
		.mispredict    (mispredict),
		.taken         (dir_taken),
		.bhr           (spec_bhr)
	);

	branch_target_buffer #(
		.btb_index_bits (btb_index_bits)
	) btb0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.fetch_pc      (pc),
		.update_valid  (update_valid),
		.update_taken  (update_taken),
		.update_pc     (update_pc),
		.update_target (update_target),
		.target        (btb_target),
		.hit           (btb_hit)
	);

endmodule

//--- source/fetch_decode_register.sv
module fetch_decode_register (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        flush,
	input  logic                        fetch_valid,
	input  front_end_pkg::rv32i_word    fetch_pc,
	input  front_end_pkg::rv32i_word    fetch_instr,
	input  front_end_pkg::predict_state fetch_predict,
	output logic                        decode_valid,
	output front_end_pkg::rv32i_word    decode_pc,
	output front_end_pkg::rv32i_word    decode_instr,
	output front_end_pkg::predict_state decode_predict
);

	logic capture;  // new fetch arrives and no flush kills it

	assign capture = fetch_valid && !flush;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			decode_valid <= 1'b0;
		end
		else if (flush)
		begin
			decode_valid <= 1'b0;  // wrong path is dropped
		end
		else
		begin
			decode_valid <= fetch_valid;  // high for one cycle per response
		end
	end

	// payload only moves with a real fetch
	always_ff @(posedge clk)
	begin
		if (capture)
		begin
			decode_pc      <= fetch_pc;
			decode_instr   <= fetch_instr;
			decode_predict <= fetch_predict;  // kept for resolve later
		end
	end

endmodule

//--- source/branch_resolve_stage.sv
module branch_resolve_stage (
	input  logic                                  clk,
	input  logic                                  rst_n,
	input  logic                                  resolve_valid,
	input  front_end_pkg::rv32i_word              resolve_pc,
	input  logic                                  resolve_is_branch,
	input  logic                                  resolve_taken,
	input  front_end_pkg::rv32i_word              resolve_target,
	input  front_end_pkg::predict_state           resolve_predict,
	output logic                                  redirect,
	output front_end_pkg::rv32i_word              redirect_pc,
	output logic                                  flush,
	output logic                                  mispredict,
	output logic                                  update_valid,
	output front_end_pkg::rv32i_word              update_pc,
	output logic                                  update_taken,
	output front_end_pkg::rv32i_word              update_target,
	output logic [front_end_pkg::max_history-1:0] update_bhr,
	output logic [31:0]                           branch_total,
	output logic [31:0]                           branch_correct,
	output logic [31:0]                           branch_incorrect
);
	import front_end_pkg::*;

	logic is_branch;       // a resolved branch this cycle
	logic wrong_dir;
	logic wrong_target;
	logic mispredict_now;

	assign is_branch    = resolve_valid && resolve_is_branch;
	assign wrong_dir    = resolve_taken != resolve_predict.taken;
	// direction matched on a taken branch but the btb pointed elsewhere
	assign wrong_target = resolve_taken && resolve_predict.taken
		&& (resolve_target != resolve_predict.target);
	assign mispredict_now = is_branch && (wrong_dir || wrong_target);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			mispredict   <= 1'b0;
			update_valid <= 1'b0;
		end
		else
		begin
			mispredict   <= mispredict_now;  // one cycle after resolve_valid
			update_valid <= is_branch;       // non-branches never train
		end
	end

	// same pulse steers fetch and empties decode
	assign redirect = mispredict;
	assign flush    = mispredict;

	always_ff @(posedge clk)
	begin
		if (is_branch)
		begin
			redirect_pc   <= resolve_taken ? resolve_target : resolve_pc + pc_step;
			update_pc     <= resolve_pc;
			update_taken  <= resolve_taken;
			update_target <= resolve_target;
			update_bhr    <= resolve_predict.bhr;  // history seen at fetch
		end
	end

	// statistics
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			branch_total     <= '0;
			branch_correct   <= '0;
			branch_incorrect <= '0;
		end
		else if (is_branch)
		begin
			branch_total <= branch_total + 32'd1;
			if (mispredict_now)
				branch_incorrect <= branch_incorrect + 32'd1;
			else
				branch_correct <= branch_correct + 32'd1;
		end
	end

endmodule

//--- source/front_end.sv
module front_end #(
	parameter int history_bits   = 5,
	parameter int btb_index_bits = 6
) (
	input  logic                        clk,
	input  logic                        rst_n,
	output logic                        read,
	output front_end_pkg::rv32i_word    address,
	input  logic                        resp,
	input  front_end_pkg::rv32i_word    rdata,
	input  logic                        resolve_valid,
	input  front_end_pkg::rv32i_word    resolve_pc,
	input  logic                        resolve_is_branch,
	input  logic                        resolve_taken,
	input  front_end_pkg::rv32i_word    resolve_target,
	input  front_end_pkg::predict_state resolve_predict,
	output logic                        decode_valid,
	output front_end_pkg::rv32i_word    decode_pc,
	output front_end_pkg::rv32i_word    decode_instr,
	output front_end_pkg::predict_state decode_predict,
	output logic [31:0]                 branch_total,
	output logic [31:0]                 branch_correct,
	output logic [31:0]                 branch_incorrect
);
	import front_end_pkg::*;

	// fetch to decode
	logic         fetch_valid;
	rv32i_word    fetch_pc;
	rv32i_word    fetch_instr;
	predict_state fetch_predict;

	// resolve back to fetch
	logic                   redirect;
	rv32i_word              redirect_pc;
	logic                   flush;
	logic                   mispredict;
	logic                   update_valid;
	rv32i_word              update_pc;
	logic                   update_taken;
	rv32i_word              update_target;
	logic [max_history-1:0] update_bhr;

	fetch_stage #(
		.history_bits   (history_bits),
		.btb_index_bits (btb_index_bits)
	) fetch0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.resp          (resp),
		.rdata         (rdata),
		.redirect      (redirect),
		.redirect_pc   (redirect_pc),
		.update_valid  (update_valid),
		.update_pc     (update_pc),
		.update_taken  (update_taken),
		.update_target (update_target),
		.update_bhr    (update_bhr),
		.mispredict    (mispredict),
		.read          (read),
		.address       (address),
		.fetch_valid   (fetch_valid),
		.fetch_pc      (fetch_pc),
		.fetch_instr   (fetch_instr),
		.fetch_predict (fetch_predict)
	);

	fetch_decode_register fd_reg0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.flush          (flush),
		.fetch_valid    (fetch_valid),
		.fetch_pc       (fetch_pc),
		.fetch_instr    (fetch_instr),
		.fetch_predict  (fetch_predict),
		.decode_valid   (decode_valid),
		.decode_pc      (decode_pc),
		.decode_instr   (decode_instr),
		.decode_predict (decode_predict)
	);

	branch_resolve_stage resolve0 (
		.clk               (clk),
		.rst_n             (rst_n),
		.resolve_valid     (resolve_valid),
		.resolve_pc        (resolve_pc),
		.resolve_is_branch (resolve_is_branch),
		.resolve_taken     (resolve_taken),
		.resolve_target    (resolve_target),
		.resolve_predict   (resolve_predict),
		.redirect          (redirect),
		.redirect_pc       (redirect_pc),
		.flush             (flush),
		.mispredict        (mispredict),
		.update_valid      (update_valid),
		.update_pc         (update_pc),
		.update_taken      (update_taken),
		.update_target     (update_target),
		.update_bhr        (update_bhr),
		.branch_total      (branch_total),
		.branch_correct    (branch_correct),
		.branch_incorrect  (branch_incorrect)
	);

endmodule

//--- tb/front_end_tb.sv
module front_end_tb;
	import front_end_pkg::*;

	localparam int hb = 5;
	localparam int bb = 6;
	localparam int tag_bits = 30 - bb;
	localparam int max_cycles = 4000;  // 200 random resolutions at about 8 cycles plus directed tests
	localparam rv32i_word loop_head = 32'h0000_0040;
	localparam rv32i_word loop_branch = 32'h0000_0050;

	logic         clk;
	logic         rst_n;
	logic         read;
	rv32i_word    address;
	logic         resp;
	rv32i_word    rdata;
	logic         resolve_valid;
	rv32i_word    resolve_pc;
	logic         resolve_is_branch;
	logic         resolve_taken;
	rv32i_word    resolve_target;
	predict_state resolve_predict;
	logic         decode_valid;
	rv32i_word    decode_pc;
	rv32i_word    decode_instr;
	predict_state decode_predict;
	logic [31:0]  branch_total;
	logic [31:0]  branch_correct;
	logic [31:0]  branch_incorrect;

	// reference state, mirrors the tables by the predictor rules
	logic [1:0]          m_pht [2**hb];
	logic [hb-1:0]       m_ghr;
	logic [2**bb-1:0]    m_valid;
	logic [tag_bits-1:0] m_tag [2**bb];
	rv32i_word           m_target [2**bb];
	rv32i_word           m_pc;
	logic                m_read;
	logic                m_redirect;
	rv32i_word           m_redirect_pc;
	logic                u_valid;
	logic                u_mis;
	logic                u_taken;
	rv32i_word           u_pc;
	rv32i_word           u_target;
	logic [hb-1:0]       u_bhr;
	logic                exp_valid;
	rv32i_word           exp_pc;
	rv32i_word           exp_instr;
	predict_state        exp_pred;
	int                  ref_total;
	int                  ref_correct;
	int                  ref_incorrect;

	int  errors;
	int  checks;
	int  cycles;
	int  test_start;
	logic pending;  // memory request in flight
	int  wait_left;

	front_end #(
		.history_bits   (hb),
		.btb_index_bits (bb)
	) dut0 (
		.clk               (clk),
		.rst_n             (rst_n),
		.read              (read),
		.address           (address),
		.resp              (resp),
		.rdata             (rdata),
		.resolve_valid     (resolve_valid),
		.resolve_pc        (resolve_pc),
		.resolve_is_branch (resolve_is_branch),
		.resolve_taken     (resolve_taken),
		.resolve_target    (resolve_target),
		.resolve_predict   (resolve_predict),
		.decode_valid      (decode_valid),
		.decode_pc         (decode_pc),
		.decode_instr      (decode_instr),
		.decode_predict    (decode_predict),
		.branch_total      (branch_total),
		.branch_correct    (branch_correct),
		.branch_incorrect  (branch_incorrect)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// direction from the reference counter table
	function automatic logic gshare_dir(input rv32i_word pc);
		return m_pht[pc[hb+1:2] ^ m_ghr][1];
	endfunction

	// expected prediction for a fetch at pc
	function automatic predict_state predict_ref(input rv32i_word pc);
		predict_state p;
		logic [bb-1:0] bi;
		bi = pc[bb+1:2];
		p = '0;
		p.taken = gshare_dir(pc) && m_valid[bi] && (m_tag[bi] == pc[31:bb+2]);
		p.target = m_target[bi];
		p.bhr[hb-1:0] = m_ghr;
		return p;
	endfunction

	// reference model steps on the same edges as the design
	always @(posedge clk)
	begin : ref_model
		predict_state p;
		logic dir;
		logic acc;
		logic isb;
		logic mis;
		logic [hb-1:0] ui;
		rv32i_word nxt;
		if (!rst_n)
		begin
			for (int i = 0; i < 2**hb; i++)
				m_pht[i] = 2'b01;  // weakly not taken
			for (int i = 0; i < 2**bb; i++)
				m_target[i] = '0;
			m_valid = '0;
			m_ghr = '0;
			m_pc = reset_pc;
			m_read = 1'b1;
			m_redirect = 1'b0;
			u_valid = 1'b0;
			u_mis = 1'b0;
			exp_valid = 1'b0;
			ref_total = 0;
			ref_correct = 0;
			ref_incorrect = 0;
		end
		else
		begin
			p = predict_ref(m_pc);
			dir = gshare_dir(m_pc);
			acc = resp && m_read && !m_redirect;  // stale responses dropped
			isb = resolve_valid && resolve_is_branch;
			mis = isb && ((resolve_taken != resolve_predict.taken)
				|| (resolve_taken && resolve_predict.taken
				&& resolve_target != resolve_predict.target));
			if (m_redirect)
				nxt = m_redirect_pc;
			else if (p.taken)
				nxt = p.target;
			else
				nxt = m_pc + 32'd4;
			exp_valid = acc;
			if (acc)
			begin
				exp_pc = m_pc;
				exp_instr = rdata;
				exp_pred = p;
			end
			if (u_valid)
			begin
				ui = u_pc[hb+1:2] ^ u_bhr;
				if (u_taken && m_pht[ui] != 2'b11)
					m_pht[ui] = m_pht[ui] + 2'd1;
				else if (!u_taken && m_pht[ui] != 2'b00)
					m_pht[ui] = m_pht[ui] - 2'd1;
				if (u_taken)
				begin
					m_valid[u_pc[bb+1:2]] = 1'b1;
					m_tag[u_pc[bb+1:2]] = u_pc[31:bb+2];
					m_target[u_pc[bb+1:2]] = u_target;
				end
			end
			if (u_valid && u_mis)
				m_ghr = {u_bhr[hb-2:0], u_taken};  // history repair
			else if (acc)
				m_ghr = {m_ghr[hb-2:0], dir};
			if (m_redirect || acc)
				m_pc = nxt;
			m_read = !m_redirect;
			if (isb)
			begin
				ref_total++;
				if (mis)
					ref_incorrect++;
				else
					ref_correct++;
				u_pc = resolve_pc;
				u_taken = resolve_taken;
				u_target = resolve_target;
				u_bhr = resolve_predict.bhr[hb-1:0];
				m_redirect_pc = resolve_taken ? resolve_target : resolve_pc + 32'd4;
			end
			u_valid = isb;
			u_mis = mis;
			m_redirect = mis;
		end
	end

	task automatic check(input logic ok, input string msg);
		checks++;
		assert (ok)
		else
		begin
			$display("FAILED at %0t: %s", $time, msg);
			errors++;
		end
	endtask

	// compares the DUT against the reference every cycle
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			check(read === m_read, "read level");
			if (m_read)
				check(address === m_pc, $sformatf("address %h, expected %h", address, m_pc));
			check(decode_valid === exp_valid, "decode_valid");
			if (exp_valid)
			begin
				check(decode_pc === exp_pc, $sformatf("decode_pc %h, expected %h",
					decode_pc, exp_pc));
				check(decode_instr === exp_instr, "decode_instr");
				check(decode_predict.taken === exp_pred.taken, "decode_predict.taken");
				check(decode_predict.bhr === exp_pred.bhr, "decode_predict.bhr");
				if (exp_pred.taken)
					check(decode_predict.target === exp_pred.target, "decode_predict.target");
			end
			check(branch_total === ref_total, "branch_total");
			check(branch_correct === ref_correct, "branch_correct");
			check(branch_incorrect === ref_incorrect, "branch_incorrect");
		end
	end

	// instruction memory with 1 to 4 cycles of latency
	always @(negedge clk)
	begin
		resp = 1'b0;
		if (!rst_n || !read)
			pending = 1'b0;  // redirect cancels the request
		else
		begin
			if (!pending)
			begin
				pending = 1'b1;
				wait_left = $urandom % 4 + 1;
			end
			wait_left--;
			if (wait_left == 0)
			begin
				resp = 1'b1;
				rdata = $urandom;
				pending = 1'b0;
			end
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= max_cycles)
		begin
			$display("timeout: the run did not finish within %0d cycles", max_cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic wait_decode();
		do
			@(negedge clk);
		while (!decode_valid);
	endtask

	// one-cycle execute outcome, driven on the falling edge
	task automatic resolve(input rv32i_word pc, input logic is_branch, input logic taken,
		input rv32i_word target, input predict_state pred);
		resolve_valid = 1'b1;
		resolve_pc = pc;
		resolve_is_branch = is_branch;
		resolve_taken = taken;
		resolve_target = target;
		resolve_predict = pred;
		@(negedge clk);
		resolve_valid = 1'b0;
	endtask

	// next read address must reach target two cycles after the redirect
	task automatic expect_fetch(input rv32i_word target);
		logic seen;
		seen = 1'b0;
		repeat (2)
		begin
			if (!seen)
			begin
				@(negedge clk);
				seen = read && address == target;
			end
		end
		check(seen, $sformatf("no read from redirect target %h", target));
	endtask

	task automatic report(input string name);
		$display("test %s: %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	initial
	begin : main
		predict_state p;
		rv32i_word last_pc;
		logic seen_taken;
		logic branch_pick;
		int n_branch;
		logic [31:0] total_before;
		void'($urandom(32'h4504));
		errors = 0;
		checks = 0;
		cycles = 0;
		test_start = 0;
		pending = 1'b0;
		wait_left = 0;
		rst_n = 1'b0;
		resp = 1'b0;
		rdata = '0;
		resolve_valid = 1'b0;
		resolve_pc = '0;
		resolve_is_branch = 1'b0;
		resolve_taken = 1'b0;
		resolve_target = '0;
		resolve_predict = '0;
		repeat (16) @(negedge clk);
		rst_n = 1'b1;

		check(read && address === reset_pc, "first read is not at reset_pc");
		wait_decode();
		last_pc = decode_pc;
		repeat (20)
		begin
			wait_decode();
			check(decode_pc === last_pc + 32'd4, "sequential decode_pc");
			last_pc = decode_pc;
		end
		report("sequential fetch");

		wait_decode();
		resolve(decode_pc, 1'b1, 1'b1, 32'h0000_0100, decode_predict);
		expect_fetch(32'h0000_0100);
		report("taken branch redirect");

		wait_decode();
		p = decode_predict;
		p.taken = 1'b1;
		p.target = 32'h0000_0200;
		last_pc = decode_pc;
		resolve(last_pc, 1'b1, 1'b0, 32'h0000_0200, p);
		expect_fetch(last_pc + 32'd4);
		wait_decode();
		p = decode_predict;
		p.taken = 1'b1;
		p.target = 32'h0000_0300;
		resolve(decode_pc, 1'b1, 1'b1, 32'h0000_0180, p);
		expect_fetch(32'h0000_0180);
		report("mispredicted direction and target");

		wait_decode();
		resolve(decode_pc, 1'b1, 1'b1, loop_head, decode_predict);
		seen_taken = 1'b0;
		for (int i = 0; i < 16 && !seen_taken; i++)
		begin
			do
				wait_decode();
			while (decode_pc != loop_branch);
			if (exp_pred.taken)  // reference tables now say taken
			begin
				seen_taken = 1'b1;
				check(decode_predict.taken === 1'b1, "trained branch not predicted taken");
				check(address === loop_head, "predicted branch did not fetch its target");
			end
			resolve(loop_branch, 1'b1, 1'b1, loop_head, decode_predict);
		end
		check(seen_taken, "loop branch never predicted taken");
		report("trained loop branch");

		total_before = branch_total;
		n_branch = 0;
		repeat (200)
		begin
			wait_decode();
			branch_pick = ($urandom % 4) != 0;  // about one in four is not a branch
			if (branch_pick)
				n_branch++;
			resolve(decode_pc, branch_pick, $urandom % 2,
				($urandom % 64) << 2, decode_predict);
		end
		@(negedge clk);
		check(branch_total - total_before === n_branch,
			"branch_total does not match the number of resolved branches");
		report("random resolutions");

		$display("checks %0d, errors %0d, branches %0d", checks, errors, ref_total);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- files.f
source/front_end_pkg.sv
source/gshare_predictor.sv
source/branch_target_buffer.sv
source/fetch_stage.sv
source/fetch_decode_register.sv
source/branch_resolve_stage.sv
source/front_end.sv
tb/front_end_tb.sv

//--- Bender.yml
package:
  name: front_end

sources:
  - source/front_end_pkg.sv
  - source/gshare_predictor.sv
  - source/branch_target_buffer.sv
  - source/fetch_stage.sv
  - source/fetch_decode_register.sv
  - source/branch_resolve_stage.sv
  - source/front_end.sv
  - target: simulation
    files:
      - tb/front_end_tb.sv
